//--- memSysPkg.sv
// Bus widths, AHB transfer-size codes and the byte-mask to size conversion
package memSysPkg;

  // Word and byte-address widths of every bus in the subsystem
  localparam int dataWidth = 32;
  localparam int addrWidth = 32;

  // AHB HSIZE encodings
  localparam logic [2:0] hSizeByte = 3'b000;
  localparam logic [2:0] hSizeHalf = 3'b001;
  localparam logic [2:0] hSizeWord = 3'b010;

  // Single lane is a byte, an aligned lane pair is a halfword, anything else a word
  function automatic logic [2:0] byteMaskToSize(input logic [dataWidth/8-1:0] byteMask);
    logic [2:0] size;
    case (byteMask)
      4'b0001, 4'b0010, 4'b0100, 4'b1000:
        size = hSizeByte;
      4'b0011, 4'b1100:
        size = hSizeHalf;
      default:
        size = hSizeWord;
    endcase
    return size;
  endfunction

endpackage

//--- instrCache.sv
`timescale 1ns/1ps
// Direct-mapped read-only instruction cache with line fill, uncached fetch and invalidate
module instrCache #(
  parameter int numLines   = 64,
  parameter int blockWords = 4
) (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            enable,
  input  logic                            invalidate,
  input  logic [memSysPkg::addrWidth-1:0] addr,
  output logic [memSysPkg::dataWidth-1:0] instr,
  output logic                            stall,
  input  logic                            busReady,
  input  logic [memSysPkg::dataWidth-1:0] busRdata,
  output logic                            busRequest,
  output logic [memSysPkg::addrWidth-1:0] busAddr
);

  localparam int offsetBits = $clog2(blockWords);
  localparam int indexBits  = $clog2(numLines);
  localparam int tagBits    = memSysPkg::addrWidth - indexBits - offsetBits - 2;

  typedef enum logic [1:0] {sIdle, sFill, sSingle} stateT;

  stateT                           state;
  logic [tagBits-1:0]              tagMem [numLines];
  logic [numLines-1:0]             validMem;
  logic [memSysPkg::dataWidth-1:0] dataMem [numLines*blockWords];

  logic [tagBits-1:0]              tag;
  logic [indexBits-1:0]            index;
  logic [offsetBits-1:0]           offset;
  logic [offsetBits-1:0]           wordCnt;
  logic                            hit;
  logic                            lastWord;
  logic                            needFetch;
  logic                            bypassValid;
  logic [memSysPkg::dataWidth-1:0] bypassWord;

  assign {tag, index, offset} = addr[memSysPkg::addrWidth-1:2];
  assign hit      = validMem[index] && (tagMem[index] == tag);
  assign lastWord = (wordCnt == offsetBits'(blockWords - 1));

  // Disabled cache completes once the bypass word has arrived
  assign needFetch  = enable ? !hit : !bypassValid;
  assign stall      = (state != sIdle) || needFetch;
  assign instr      = enable ? dataMem[{index, offset}] : bypassWord;
  assign busRequest = (state != sIdle);
  assign busAddr    = (state == sFill) ? {tag, index, wordCnt, 2'b00}
                                       : {addr[memSysPkg::addrWidth-1:2], 2'b00};

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      state       <= sIdle;
      wordCnt     <= '0;
      bypassValid <= 1'b0;
    end
    else
    begin
      case (state)
        sIdle:
        begin
          bypassValid <= 1'b0;
          wordCnt     <= '0;
          if (needFetch)
            state <= enable ? sFill : sSingle;
        end
        sFill:
          if (busReady)
          begin
            wordCnt <= wordCnt + 1'b1;
            if (lastWord)
              state <= sIdle;
          end
        default:
          if (busReady)
          begin
            bypassValid <= 1'b1;
            state       <= sIdle;
          end
      endcase
    end
  end

  // Invalidate drops every line at once, even one that is just finishing its fill
  always_ff @(posedge clk)
  begin
    if (!rstN || invalidate)
      validMem <= '0;
    else if (state == sFill && busReady && lastWord)
      validMem[index] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (state == sFill && busReady)
    begin
      dataMem[{index, wordCnt}] <= busRdata;
      if (lastWord)
        tagMem[index] <= tag;
    end
    if (state == sSingle && busReady)
      bypassWord <= busRdata;
  end

  busAddrStable: assert property (@(posedge clk) disable iff (!rstN)
    busRequest && !busReady |=> $stable(busAddr))
    else $error("instrCache: bus address moved before ready");

endmodule

//--- dataCache.sv
`timescale 1ns/1ps
// Direct-mapped write-back data cache with byte writes, victim write-back and uncached path
module dataCache #(
  parameter int numLines   = 64,
  parameter int blockWords = 4
) (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              enable,
  input  logic [memSysPkg::addrWidth-1:0]   addr,
  input  logic [memSysPkg::dataWidth-1:0]   writeData,
  input  logic [memSysPkg::dataWidth/8-1:0] byteMask,
  input  logic                              memWrite,
  input  logic                              memRead,
  output logic [memSysPkg::dataWidth-1:0]   readData,
  output logic                              stall,
  input  logic                              busReady,
  input  logic [memSysPkg::dataWidth-1:0]   busRdata,
  output logic                              busRequest,
  output logic                              busWrite,
  output logic [memSysPkg::addrWidth-1:0]   busAddr,
  output logic [2:0]                        busSize,
  output logic [memSysPkg::dataWidth-1:0]   busWdata
);

  localparam int offsetBits = $clog2(blockWords);
  localparam int indexBits  = $clog2(numLines);
  localparam int tagBits    = memSysPkg::addrWidth - indexBits - offsetBits - 2;
  localparam int laneCount  = memSysPkg::dataWidth / 8;

  typedef enum logic [1:0] {sIdle, sWriteBack, sFill, sUncached} stateT;

  stateT                           state;
  logic [tagBits-1:0]              tagMem [numLines];
  logic [numLines-1:0]             validMem;
  logic [numLines-1:0]             dirtyMem;
  logic [memSysPkg::dataWidth-1:0] dataMem [numLines*blockWords];

  logic [tagBits-1:0]              tag;
  logic [indexBits-1:0]            index;
  logic [offsetBits-1:0]           offset;
  logic [offsetBits-1:0]           wordCnt;
  logic                            access;
  logic                            hit;
  logic                            writeHit;
  logic                            lastWord;
  logic                            needBus;
  logic                            bypassDone;
  logic [memSysPkg::dataWidth-1:0] bypassWord;

  assign {tag, index, offset} = addr[memSysPkg::addrWidth-1:2];
  assign access   = memRead || memWrite;
  assign hit      = validMem[index] && (tagMem[index] == tag);
  assign writeHit = (state == sIdle) && enable && memWrite && hit;
  assign lastWord = (wordCnt == offsetBits'(blockWords - 1));

  assign needBus    = access && (enable ? !hit : !bypassDone);
  assign stall      = (state != sIdle) || needBus;
  assign readData   = enable ? dataMem[{index, offset}] : bypassWord;
  assign busRequest = (state != sIdle);
  assign busWrite   = (state == sWriteBack) || (state == sUncached && memWrite);

  always_comb
  begin
    busAddr  = {tag, index, wordCnt, 2'b00};
    busSize  = memSysPkg::hSizeWord;
    busWdata = '0;
    case (state)
      sWriteBack:
      begin
        // Victim address comes from the stored tag
        busAddr  = {tagMem[index], index, wordCnt, 2'b00};
        busWdata = dataMem[{index, wordCnt}];
      end
      sUncached:
      begin
        busAddr  = addr;
        busSize  = memSysPkg::byteMaskToSize(byteMask);
        busWdata = writeData;
      end
      default:
        ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      state      <= sIdle;
      wordCnt    <= '0;
      bypassDone <= 1'b0;
    end
    else
    begin
      case (state)
        sIdle:
        begin
          bypassDone <= 1'b0;
          wordCnt    <= '0;
          if (needBus)
          begin
            if (!enable)
              state <= sUncached;
            else if (validMem[index] && dirtyMem[index])
              state <= sWriteBack;
            else
              state <= sFill;
          end
        end
        sWriteBack, sFill:
          if (busReady)
          begin
            wordCnt <= wordCnt + 1'b1;
            if (lastWord)
              state <= (state == sWriteBack) ? sFill : sIdle;
          end
        default:
          if (busReady)
          begin
            bypassDone <= 1'b1;
            state      <= sIdle;
          end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      validMem <= '0;
      dirtyMem <= '0;
    end
    else if (state == sFill && busReady && lastWord)
    begin
      validMem[index] <= 1'b1;
      dirtyMem[index] <= 1'b0;
    end
    else if (writeHit)
      dirtyMem[index] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (state == sFill && busReady)
    begin
      dataMem[{index, wordCnt}] <= busRdata;
      if (lastWord)
        tagMem[index] <= tag;
    end
    // Merge only the enabled byte lanes
    if (writeHit)
      for (int b = 0; b < laneCount; b++)
        if (byteMask[b])
          dataMem[{index, offset}][8*b +: 8] <= writeData[8*b +: 8];
    if (state == sUncached && busReady)
      bypassWord <= busRdata;
  end

  addrHeldInFill: assert property (@(posedge clk) disable iff (!rstN)
    state == sFill |-> $stable(addr))
    else $error("dataCache: address changed in the middle of a line fill");

  readWriteExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(memRead && memWrite))
    else $error("dataCache: memRead and memWrite high together");

endmodule

//--- busArbiter.sv
`timescale 1ns/1ps
// Fixed-priority two-master bus arbiter with a grant held across bursts
module busArbiter (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            iRequest,
  input  logic [memSysPkg::addrWidth-1:0] iAddr,
  input  logic                            dRequest,
  input  logic [memSysPkg::addrWidth-1:0] dAddr,
  input  logic                            dWrite,
  input  logic [2:0]                      dSize,
  input  logic [memSysPkg::dataWidth-1:0] dWdata,
  output logic                            iReady,
  output logic                            dReady,
  output logic                            hRequest,
  output logic [memSysPkg::addrWidth-1:0] hAddr,
  output logic                            hWrite,
  output logic [2:0]                      hSize,
  output logic [memSysPkg::dataWidth-1:0] hWdata,
  input  logic                            hReady
);

  logic grantD;
  logic held;
  logic selD;

  // Owner keeps the bus while its request stays up, otherwise data side first
  always_comb
  begin
    if (held && (grantD ? dRequest : iRequest))
      selD = grantD;
    else if (dRequest)
      selD = 1'b1;
    else if (iRequest)
      selD = 1'b0;
    else
      selD = grantD;
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      grantD <= 1'b0;
      held   <= 1'b0;
    end
    else
    begin
      grantD <= selD;
      held   <= hRequest;
    end
  end

  assign hRequest = selD ? dRequest : iRequest;
  assign hAddr    = selD ? dAddr : iAddr;
  assign hWrite   = selD && dWrite;
  // Fetches are always full words
  assign hSize    = selD ? dSize : memSysPkg::hSizeWord;
  assign hWdata   = selD ? dWdata : '0;

  assign iReady = hReady && !selD;
  assign dReady = hReady && selD;

  grantHeld: assert property (@(posedge clk) disable iff (!rstN)
    hRequest && !hReady |=> hRequest && $stable(selD))
    else $error("busArbiter: grant moved before the owner's transfer completed");

endmodule

//--- ahbMemory.sv
`timescale 1ns/1ps
// Word-addressed AHB-lite memory slave with fixed wait states and sized writes
module ahbMemory #(
  parameter int memWords   = 4096,
  parameter int waitStates = 2
) (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            hRequest,
  input  logic [memSysPkg::addrWidth-1:0] hAddr,
  input  logic                            hWrite,
  input  logic [2:0]                      hSize,
  input  logic [memSysPkg::dataWidth-1:0] hWdata,
  output logic [memSysPkg::dataWidth-1:0] hRdata,
  output logic                            hReady
);

  localparam int idxBits   = $clog2(memWords);
  localparam int cntBits   = $clog2(waitStates + 1) + 1;
  localparam int laneCount = memSysPkg::dataWidth / 8;

  logic [memSysPkg::dataWidth-1:0] mem [memWords];
  logic [cntBits-1:0]              waitCnt;
  logic [idxBits-1:0]              wordIdx;
  logic [laneCount-1:0]            laneMask;

  assign wordIdx = hAddr[2 +: idxBits];
  assign hRdata  = mem[wordIdx];
  // Ready in the last counted cycle, so a word costs waitStates+1 cycles
  assign hReady  = hRequest && (waitCnt == cntBits'(waitStates));

  always_comb
  begin
    case (hSize)
      memSysPkg::hSizeByte:
        laneMask = 4'b0001 << hAddr[1:0];
      memSysPkg::hSizeHalf:
        laneMask = hAddr[1] ? 4'b1100 : 4'b0011;
      default:
        laneMask = 4'b1111;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
      waitCnt <= '0;
    else if (hRequest && !hReady)
      waitCnt <= waitCnt + 1'b1;
    else
      waitCnt <= '0;
  end

  always_ff @(posedge clk)
  begin
    if (hReady && hWrite)
      for (int b = 0; b < laneCount; b++)
        if (laneMask[b])
          mem[wordIdx][8*b +: 8] <= hWdata[8*b +: 8];
  end

  addrInRange: assert property (@(posedge clk) disable iff (!rstN)
    hRequest |-> (hAddr >> 2) < memWords)
    else $error("ahbMemory: address %h beyond memory", hAddr);

endmodule

//--- memSubsystem.sv
`timescale 1ns/1ps
// Memory subsystem top: instruction and data caches, bus arbiter and memory
module memSubsystem #(
  parameter int numLines   = 64,
  parameter int blockWords = 4,
  parameter int memWords   = 4096,
  parameter int waitStates = 2
) (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              iEnable,
  input  logic                              iInvalidate,
  input  logic [memSysPkg::addrWidth-1:0]   instrAddr,
  output logic [memSysPkg::dataWidth-1:0]   instr,
  output logic                              iStall,
  input  logic                              dEnable,
  input  logic [memSysPkg::addrWidth-1:0]   dataAddr,
  input  logic [memSysPkg::dataWidth-1:0]   writeData,
  input  logic [memSysPkg::dataWidth/8-1:0] byteMask,
  input  logic                              memWrite,
  input  logic                              memRead,
  output logic [memSysPkg::dataWidth-1:0]   readData,
  output logic                              dStall
);

  // Cache-side bus masters
  logic                            iBusRequest, iBusReady;
  logic [memSysPkg::addrWidth-1:0] iBusAddr;
  logic                            dBusRequest, dBusReady, dBusWrite;
  logic [memSysPkg::addrWidth-1:0] dBusAddr;
  logic [2:0]                      dBusSize;
  logic [memSysPkg::dataWidth-1:0] dBusWdata;
  // Shared memory bus
  logic                            hRequest, hWrite, hReady;
  logic [memSysPkg::addrWidth-1:0] hAddr;
  logic [2:0]                      hSize;
  logic [memSysPkg::dataWidth-1:0] hWdata, hRdata;

  instrCache #(.numLines(numLines), .blockWords(blockWords)) iCache (
    .clk(clk), .rstN(rstN), .enable(iEnable), .invalidate(iInvalidate),
    .addr(instrAddr), .instr(instr), .stall(iStall),
    .busReady(iBusReady), .busRdata(hRdata),
    .busRequest(iBusRequest), .busAddr(iBusAddr)
  );

  dataCache #(.numLines(numLines), .blockWords(blockWords)) dCache (
    .clk(clk), .rstN(rstN), .enable(dEnable), .addr(dataAddr),
    .writeData(writeData), .byteMask(byteMask), .memWrite(memWrite), .memRead(memRead),
    .readData(readData), .stall(dStall), .busReady(dBusReady), .busRdata(hRdata),
    .busRequest(dBusRequest), .busWrite(dBusWrite), .busAddr(dBusAddr),
    .busSize(dBusSize), .busWdata(dBusWdata)
  );

  busArbiter arbiter (
    .clk(clk), .rstN(rstN),
    .iRequest(iBusRequest), .iAddr(iBusAddr),
    .dRequest(dBusRequest), .dAddr(dBusAddr), .dWrite(dBusWrite),
    .dSize(dBusSize), .dWdata(dBusWdata),
    .iReady(iBusReady), .dReady(dBusReady),
    .hRequest(hRequest), .hAddr(hAddr), .hWrite(hWrite),
    .hSize(hSize), .hWdata(hWdata), .hReady(hReady)
  );

  ahbMemory #(.memWords(memWords), .waitStates(waitStates)) memory (
    .clk(clk), .rstN(rstN), .hRequest(hRequest), .hAddr(hAddr), .hWrite(hWrite),
    .hSize(hSize), .hWdata(hWdata), .hRdata(hRdata), .hReady(hReady)
  );

endmodule

//--- tbMemSubsystem.sv
`timescale 1ns/1ps
// Testbench for the memory subsystem with clock, reset, reference memory, access tasks and checks
module tbMemSubsystem;

  localparam int clkPeriod   = 40;
  localparam int driveDelay  = 1;
  localparam int resetCycles = 10;
  localparam int numLines    = 64;
  localparam int blockWords  = 4;
  localparam int memWords    = 4096;
  localparam int waitStates  = 2;
  localparam int memIdxBits  = $clog2(memWords);
  localparam int lineBytes   = blockWords * 4;

  // Worst access is a write-back plus a fill, queued behind a fill of the other master
  localparam int worstAccessCycles = 3 * blockWords * (waitStates + 1) + 4;
  localparam int accessBudget      = 250;
  localparam int timeoutCycles     = resetCycles + 2 * accessBudget * worstAccessCycles;

  // Test regions
  localparam logic [31:0] uncachedBase  = 32'h0000_0000;
  localparam logic [31:0] lineBase      = 32'h0000_1000;
  // Same cache index as lineBase, next tag
  localparam logic [31:0] conflictBase  = lineBase + 32'(numLines * lineBytes);
  localparam logic [31:0] fetchBase     = 32'h0000_2000;
  localparam logic [31:0] fetchRaceBase = 32'h0000_2800;
  localparam logic [31:0] dataRaceBase  = 32'h0000_3040;

  logic                              clk;
  logic                              rstN;
  logic                              iEnable;
  logic                              iInvalidate;
  logic [memSysPkg::addrWidth-1:0]   instrAddr;
  logic [memSysPkg::dataWidth-1:0]   instr;
  logic                              iStall;
  logic                              dEnable;
  logic [memSysPkg::addrWidth-1:0]   dataAddr;
  logic [memSysPkg::dataWidth-1:0]   writeData;
  logic [memSysPkg::dataWidth/8-1:0] byteMask;
  logic                              memWrite;
  logic                              memRead;
  logic [memSysPkg::dataWidth-1:0]   readData;
  logic                              dStall;

  // Reference memory and expectations of the access in flight
  logic [memSysPkg::dataWidth-1:0] refMem [memWords];
  logic [memSysPkg::dataWidth-1:0] dExpect;
  logic [memSysPkg::dataWidth-1:0] dLaneBits;
  logic                            dCheck;
  logic                            expectHit;
  logic [memSysPkg::dataWidth-1:0] iExpect;
  logic                            iCheck;

  int seed           = 44392;
  int cycleCount     = 0;
  int loadsIssued    = 0;
  int loadsChecked   = 0;
  int fetchesIssued  = 0;
  int fetchesChecked = 0;

  memSubsystem #(
    .numLines(numLines),
    .blockWords(blockWords),
    .memWords(memWords),
    .waitStates(waitStates)
  ) DUT (
    .clk(clk), .rstN(rstN), .iEnable(iEnable), .iInvalidate(iInvalidate),
    .instrAddr(instrAddr), .instr(instr), .iStall(iStall),
    .dEnable(dEnable), .dataAddr(dataAddr), .writeData(writeData), .byteMask(byteMask),
    .memWrite(memWrite), .memRead(memRead), .readData(readData), .dStall(dStall)
  );

  task automatic reportFailure(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  function automatic logic [31:0] laneBits(input logic [3:0] mask);
    logic [31:0] bits;
    for (int b = 0; b < 4; b++)
      bits[8*b +: 8] = {8{mask[b]}};
    return bits;
  endfunction

  // Byte-merge rule applied to the reference memory
  task automatic modelStore(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] mask);
    for (int b = 0; b < 4; b++)
      if (mask[b])
        refMem[addr[2 +: memIdxBits]][8*b +: 8] = data[8*b +: 8];
  endtask

  // Random word, halfword or byte lane within one word
  task automatic pickSized(input logic [31:0] wordAddr, output logic [31:0] addr,
                           output logic [3:0] mask);
    int kind;
    int lane;
    kind = $unsigned($random(seed)) % 3;
    lane = $unsigned($random(seed)) % 4;
    case (kind)
      0:
      begin
        mask = 4'b1111;
        addr = wordAddr;
      end
      1:
      begin
        mask = lane[1] ? 4'b1100 : 4'b0011;
        addr = wordAddr + 32'(lane & 2);
      end
      default:
      begin
        mask = 4'b0001 << lane;
        addr = wordAddr + 32'(lane);
      end
    endcase
  endtask

  task automatic waitDataDone();
    @(negedge clk);
    while (dStall)
      @(negedge clk);
    @(posedge clk);
    #driveDelay;
  endtask

  task automatic waitInstrDone();
    @(negedge clk);
    while (iStall)
      @(negedge clk);
    @(posedge clk);
    #driveDelay;
  endtask

  task automatic storeData(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] mask);
    modelStore(addr, data, mask);
    dataAddr  = addr;
    writeData = data;
    byteMask  = mask;
    memWrite  = 1'b1;
    waitDataDone();
    memWrite  = 1'b0;
  endtask

  task automatic loadData(input logic [31:0] addr, input logic [3:0] mask,
                          input logic mustHit);
    dataAddr  = addr;
    byteMask  = mask;
    memRead   = 1'b1;
    dExpect   = refMem[addr[2 +: memIdxBits]];
    dLaneBits = laneBits(mask);
    dCheck    = 1'b1;
    expectHit = mustHit;
    loadsIssued++;
    waitDataDone();
    memRead   = 1'b0;
    dCheck    = 1'b0;
    expectHit = 1'b0;
  endtask

  task automatic fetchInstr(input logic [31:0] addr);
    instrAddr = addr;
    iExpect   = refMem[addr[2 +: memIdxBits]];
    iCheck    = 1'b1;
    fetchesIssued++;
    waitInstrDone();
    iCheck    = 1'b0;
  endtask

  // Pulse invalidate, then let the current line refill
  task automatic invalidateInstr();
    iInvalidate = 1'b1;
    @(posedge clk);
    #driveDelay;
    iInvalidate = 1'b0;
    waitInstrDone();
  endtask

  task automatic fillRegion(input logic [31:0] base, input int words);
    for (int i = 0; i < words; i++)
      storeData(base + 32'(4 * i), $random(seed), 4'hF);
  endtask

  readDataMatch: assert property (@(posedge clk) disable iff (!rstN)
    dCheck && memRead && !dStall |-> ((readData ^ dExpect) & dLaneBits) == '0)
    else reportFailure($sformatf("[ERROR] readData: got %h, expected %h at address %h",
      $sampled(readData), $sampled(dExpect), $sampled(dataAddr)));

  loadHitNoStall: assert property (@(posedge clk) disable iff (!rstN)
    expectHit && memRead |-> !dStall)
    else reportFailure($sformatf("[ERROR] dStall: got %h, expected %h on a hit at %h",
      $sampled(dStall), 1'b0, $sampled(dataAddr)));

  instrMatch: assert property (@(posedge clk) disable iff (!rstN)
    iCheck && !iStall |-> instr == iExpect)
    else reportFailure($sformatf("[ERROR] instr: got %h, expected %h at address %h",
      $sampled(instr), $sampled(iExpect), $sampled(instrAddr)));

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount > timeoutCycles)
      reportFailure($sformatf("Timeout: run still busy after %0d cycles", timeoutCycles));
  end

  // Completions seen from outside the tasks
  always @(negedge clk)
  begin
    if (rstN && dCheck && memRead && !dStall)
      loadsChecked++;
    if (rstN && iCheck && !iStall)
      fetchesChecked++;
  end

  initial
  begin
    logic [31:0] addr;
    logic [3:0]  mask;
    int          pick;
    rstN        = 1'b0;
    iEnable     = 1'b1;
    iInvalidate = 1'b0;
    instrAddr   = '0;
    dEnable     = 1'b0;
    dataAddr    = '0;
    writeData   = '0;
    byteMask    = '0;
    memWrite    = 1'b0;
    memRead     = 1'b0;
    dExpect     = '0;
    dLaneBits   = '0;
    dCheck      = 1'b0;
    expectHit   = 1'b0;
    iExpect     = '0;
    iCheck      = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #driveDelay;
    rstN = 1'b1;

    // Known contents for every region that is read later
    fillRegion(uncachedBase, 16);
    fillRegion(lineBase, 4 * blockWords);
    fillRegion(conflictBase, 4 * blockWords);
    fillRegion(fetchBase, 8);
    fillRegion(fetchRaceBase, 2 * blockWords);
    fillRegion(dataRaceBase, 2 * blockWords);

    // Uncached sized stores and loads
    for (int i = 0; i < 24; i++)
    begin
      pick = $unsigned($random(seed)) % 16;
      pickSized(uncachedBase + 32'(4 * pick), addr, mask);
      storeData(addr, $random(seed), mask);
      loadData(addr, mask, 1'b0);
    end
    for (int i = 0; i < 16; i++)
      loadData(uncachedBase + 32'(4 * i), 4'hF, 1'b0);

    // Cached misses, then hits in the same line
    dEnable = 1'b1;
    for (int l = 0; l < 4; l++)
    begin
      loadData(lineBase + 32'(lineBytes * l), 4'hF, 1'b0);
      for (int w = 1; w < blockWords; w++)
        loadData(lineBase + 32'(lineBytes * l + 4 * w), 4'hF, 1'b1);
    end

    // Dirty lines evicted by conflicting loads, then reloaded
    for (int i = 0; i < 4 * blockWords; i++)
    begin
      pickSized(lineBase + 32'(4 * i), addr, mask);
      storeData(addr, $random(seed), mask);
    end
    for (int i = 0; i < 4 * blockWords; i++)
      loadData(conflictBase + 32'(4 * i), 4'hF, (i % blockWords) != 0);
    for (int i = 0; i < 4 * blockWords; i++)
      loadData(lineBase + 32'(4 * i), 4'hF, (i % blockWords) != 0);

    // Fetch, rewrite behind the instruction cache, invalidate, refetch
    dEnable = 1'b0;
    for (int i = 0; i < 8; i++)
      fetchInstr(fetchBase + 32'(4 * i));
    fillRegion(fetchBase, 8);
    invalidateInstr();
    for (int i = 0; i < 8; i++)
      fetchInstr(fetchBase + 32'(4 * i));

    // Both caches miss in the same cycle
    dEnable = 1'b1;
    for (int p = 0; p < 2; p++)
      fork
        fetchInstr(fetchRaceBase + 32'(lineBytes * p));
        loadData(dataRaceBase + 32'(lineBytes * p), 4'hF, 1'b0);
      join

    if (loadsChecked == loadsIssued && fetchesChecked == fetchesIssued)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
      reportFailure($sformatf("Only %0d of %0d loads and %0d of %0d fetches were checked",
        loadsChecked, loadsIssued, fetchesChecked, fetchesIssued));
  end

endmodule

//--- files.f
memSysPkg.sv
instrCache.sv
dataCache.sv
busArbiter.sv
ahbMemory.sv
memSubsystem.sv
tbMemSubsystem.sv

//--- runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

logFile=sim.log
failMessage="FAIL: see errors above"

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tbMemSubsystem -Mdir obj_dir -o simMemSubsystem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simMemSubsystem > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "$failMessage" "$logFile"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi
echo "Simulation finished without failures"
exit 0
